//--- src.f
+incdir+verif
design/conv2_pkg.sv
design/conv2_line_buffer.sv
design/conv2_filter_mac.sv
design/conv2_weight_regs.sv
design/conv2_layer.sv
verif/conv2_tb.sv

//--- run.sh
#!/usr/bin/env bash
# build and run the conv2 layer testbench with Verilator
# the run counts as failed when the log holds the fail message

cd "$(dirname "$0")" || exit 1
LOG=sim.log

verilator --binary --timing --assert --top-module conv2_tb -f src.f -o conv2_sim > "$LOG" 2>&1 \
    && ./obj_dir/conv2_sim >> "$LOG" 2>&1 \
    || echo "test failed" >> "$LOG"

cat "$LOG"
grep -q "test failed" "$LOG" && exit 1 || exit 0

//--- verif/conv2_tb_model.svh
// conv2 reference model
// expected layer outputs computed from frame pixels and the register
// image, following the layer's output arithmetic

`ifndef CONV2_TB_MODEL_SVH
`define CONV2_TB_MODEL_SVH

    pixel_t  frame_pix [2][N_IN_CH][IMG_H][IMG_W];   // up to two frames per test
    weight_t reg_img   [N_REGS];                     // what software wrote

    // register index of tap k, filter f, channel ch
    function automatic int reg_index(int f, int ch, int k);
        return (f * N_IN_CH + ch) * K_TAPS + k;
    endfunction

    function automatic pixel_t expected_output(int fr, int f, int r, int c);
        int acc;
        int wrapped;
        int scaled;
        int tap;
        acc = 0;
        for (int ch = 0; ch < N_IN_CH; ch++) begin
            for (int kr = 0; kr < K_SIZE; kr++) begin
                for (int kc = 0; kc < K_SIZE; kc++) begin
                    tap = int'(reg_img[reg_index(f, ch, kr * K_SIZE + kc)]);
                    acc += int'(frame_pix[fr][ch][r + kr][c + kc]) * tap;
                end
            end
        end
        // keep 20 bits, bit 19 is the sign
        wrapped = acc & ((1 << SUM_W) - 1);
        if (wrapped >= (1 << (SUM_W - 1))) begin
            wrapped -= 1 << SUM_W;
        end
        scaled = wrapped >>> OUT_SHIFT;
        // low 12 bits plus bias, wraps at 12 bits
        return pixel_t'((scaled + int'(reg_img[N_WGT_REGS + f])) & ((1 << PIX_W) - 1));
    endfunction

`endif

//--- verif/conv2_tb.sv
// conv2 layer testbench
// loads kernels and biases over APB, streams pixel frames and checks
// every output against the reference model

module conv2_tb
    import conv2_pkg::*;
();
    timeunit 1ns;
    timeprecision 1ps;

    localparam int CLK_PERIOD    = 20;
    localparam int MAX_GAP       = 3;
    localparam int N_RUN_FRAMES  = 4;                   // frames streamed over all tests
    localparam int APB_OPS       = 4 * N_REGS + 16;     // 4 cycles each
    localparam int RES_PER_FRAME = OUT_W * OUT_H;
    localparam int WATCHDOG_NS   = N_RUN_FRAMES * IMG_W * IMG_H * (MAX_GAP + 1) * CLK_PERIOD
                                 + APB_OPS * 4 * CLK_PERIOD + 500 * CLK_PERIOD;

    logic              clk;
    logic              rst_n;
    logic              psel;
    logic              penable;
    logic              pwrite;
    logic [APB_AW-1:0] paddr;
    logic [APB_DW-1:0] pwdata;
    logic [APB_DW-1:0] prdata;
    logic              pready;
    logic              pslverr;
    logic              pixel_valid;
    pixel_t            pixel_in    [N_IN_CH];
    pixel_t            feature_out [N_FILT];
    logic              out_valid;

    `include "conv2_tb_model.svh"

    logic [N_FILT*PIX_W-1:0] got_q [$];   // one entry per out_valid cycle
    logic [N_FILT*PIX_W-1:0] res_word;
    string                   cur_test;
    int                      err_cnt;
    int                      test_err_base;
    int                      n_ok;
    int                      n_bad;

    conv2_layer dut_i (.*);

    initial begin
        clk = 1'b0;
        forever #(CLK_PERIOD / 2) clk = ~clk;
    end

    always_comb begin
        for (int f = 0; f < N_FILT; f++) begin
            res_word[f*PIX_W +: PIX_W] = feature_out[f];
        end
    end

    // sampled mid-cycle, away from the clock edge
    always @(negedge clk) begin
        if (rst_n && out_valid) begin
            got_q.push_back(res_word);
        end
    end

    ////////////////////////////////////////
    // checks and bookkeeping
    ////////////////////////////////////////
    task automatic check_pixel(string what, pixel_t exp, pixel_t act);
        if (act !== exp) begin
            $display("FAIL %s %s: expected %0d, actual %0d", cur_test, what, exp, act);
            err_cnt++;
        end
    endtask

    task automatic check_word(string what, logic [APB_DW-1:0] exp, logic [APB_DW-1:0] act);
        if (act !== exp) begin
            $display("FAIL %s %s: expected 0x%08h, actual 0x%08h", cur_test, what, exp, act);
            err_cnt++;
        end
    endtask

    task automatic check_flag(string what, logic exp, logic act);
        if (act !== exp) begin
            $display("FAIL %s %s: expected %b, actual %b", cur_test, what, exp, act);
            err_cnt++;
        end
    endtask

    task automatic start_test(string name);
        cur_test      = name;
        test_err_base = err_cnt;
    endtask

    task automatic finish_test();
        if (err_cnt == test_err_base) begin
            $display("%s: ok", cur_test);
            n_ok++;
        end else begin
            $display("%s: %0d errors", cur_test, err_cnt - test_err_base);
            n_bad++;
        end
    endtask

    // read-back rule, low byte of the written word sign-extended
    function automatic logic [APB_DW-1:0] sext_byte(logic [APB_DW-1:0] w);
        return {{(APB_DW - WGT_W){w[WGT_W-1]}}, w[WGT_W-1:0]};
    endfunction

    function automatic logic [APB_AW-1:0] reg_addr(int idx);
        return APB_AW'(idx * 4);
    endfunction

    ////////////////////////////////////////
    // APB and stream drivers
    ////////////////////////////////////////
    task automatic apb_write(logic [APB_AW-1:0] addr, logic [APB_DW-1:0] data,
                             output logic err);
        @(posedge clk);
        psel    <= 1'b1;   // setup phase
        penable <= 1'b0;
        pwrite  <= 1'b1;
        paddr   <= addr;
        pwdata  <= data;
        @(posedge clk);
        penable <= 1'b1;
        @(negedge clk);
        err = pslverr;
        check_flag("pready", 1'b1, pready);
        @(posedge clk);
        psel    <= 1'b0;
        penable <= 1'b0;
        pwrite  <= 1'b0;
    endtask

    task automatic apb_read(logic [APB_AW-1:0] addr, output logic [APB_DW-1:0] data,
                            output logic err);
        @(posedge clk);
        psel    <= 1'b1;
        penable <= 1'b0;
        pwrite  <= 1'b0;
        paddr   <= addr;
        @(posedge clk);
        penable <= 1'b1;
        @(negedge clk);
        data = prdata;
        err  = pslverr;
        @(posedge clk);
        psel    <= 1'b0;
        penable <= 1'b0;
    endtask

    task automatic load_registers();
        logic err;
        for (int i = 0; i < N_REGS; i++) begin
            apb_write(reg_addr(i), APB_DW'(reg_img[i]), err);
            check_flag($sformatf("pslverr on write to %0d", i), 1'b0, err);
        end
    endtask

    task automatic randomize_registers();
        for (int i = 0; i < N_REGS; i++) begin
            reg_img[i] = weight_t'($urandom);
        end
    endtask

    task automatic fill_frame(int fr);
        for (int ch = 0; ch < N_IN_CH; ch++) begin
            for (int r = 0; r < IMG_H; r++) begin
                for (int c = 0; c < IMG_W; c++) begin
                    frame_pix[fr][ch][r][c] = pixel_t'($urandom);
                end
            end
        end
    endtask

    task automatic stream_frames(int n_frames, int max_gap);
        int gap;
        for (int fr = 0; fr < n_frames; fr++) begin
            for (int r = 0; r < IMG_H; r++) begin
                for (int c = 0; c < IMG_W; c++) begin
                    gap = (max_gap > 0) ? int'($urandom % (max_gap + 1)) : 0;
                    repeat (gap) begin
                        @(posedge clk);
                        pixel_valid <= 1'b0;
                    end
                    @(posedge clk);
                    pixel_valid <= 1'b1;
                    for (int ch = 0; ch < N_IN_CH; ch++) begin
                        pixel_in[ch] <= frame_pix[fr][ch][r][c];
                    end
                end
            end
        end
        @(posedge clk);
        pixel_valid <= 1'b0;
    endtask

    // waits for n results, then a little longer to catch extras
    task automatic wait_for_results(int n);
        int waited;
        waited = 0;
        while (got_q.size() < n && waited < 50) begin
            @(posedge clk);
            waited++;
        end
        if (got_q.size() < n) begin
            $display("%s: only %0d of %0d results arrived in time", cur_test, got_q.size(), n);
            err_cnt++;
        end
        repeat (20) @(posedge clk);
        if (got_q.size() > n) begin
            $display("%s: %0d results arrived where %0d were expected",
                     cur_test, got_q.size(), n);
            err_cnt++;
        end
    endtask

    task automatic compare_with_model(int n_frames);
        logic [N_FILT*PIX_W-1:0] word;
        int                      idx;
        for (int fr = 0; fr < n_frames; fr++) begin
            for (int r = 0; r < OUT_H; r++) begin
                for (int c = 0; c < OUT_W; c++) begin
                    idx = (fr * OUT_H + r) * OUT_W + c;
                    if (idx < got_q.size()) begin
                        word = got_q[idx];
                        for (int f = 0; f < N_FILT; f++) begin
                            check_pixel($sformatf("frame %0d filter %0d at (%0d,%0d)",
                                                  fr, f, r, c),
                                        expected_output(fr, f, r, c),
                                        pixel_t'(word[f*PIX_W +: PIX_W]));
                        end
                    end
                end
            end
        end
    endtask

    ////////////////////////////////////////
    // directed tests
    ////////////////////////////////////////
    task automatic test_reset_state();
        logic [APB_DW-1:0] data;
        logic              err;
        start_test("reset_state");
        @(negedge clk);
        check_flag("out_valid", 1'b0, out_valid);
        check_flag("pslverr", 1'b0, pslverr);
        for (int i = 0; i < N_REGS; i++) begin
            apb_read(reg_addr(i), data, err);
            check_word($sformatf("register %0d", i), '0, data);
        end
        finish_test();
    endtask

    task automatic test_register_access();
        int                idx  [5] = '{0, 1, 224, 225, 227};
        logic [APB_DW-1:0] wdat [5] = '{32'h1234_56f3, 32'h0000_007f, 32'hffff_ff80,
                                        32'h0000_0105, 32'h8000_00c4};
        logic [APB_DW-1:0] data;
        logic              err;
        start_test("register_access");
        for (int i = 0; i < 5; i++) begin
            apb_write(reg_addr(idx[i]), wdat[i], err);
            check_flag($sformatf("pslverr on write to %0d", idx[i]), 1'b0, err);
        end
        for (int i = 0; i < 5; i++) begin
            apb_read(reg_addr(idx[i]), data, err);
            check_word($sformatf("register %0d", idx[i]), sext_byte(wdat[i]), data);
        end
        // one past the biases
        apb_write(reg_addr(N_REGS), 32'h0000_005a, err);
        check_flag("pslverr on write past the map", 1'b1, err);
        apb_read(reg_addr(N_REGS), data, err);
        check_flag("pslverr on read past the map", 1'b1, err);
        check_word("read data past the map", '0, data);
        // unaligned accesses
        apb_write(reg_addr(0) + APB_AW'(1), 32'h0000_0011, err);
        check_flag("pslverr on unaligned write", 1'b1, err);
        apb_read(reg_addr(0), data, err);
        check_word("register 0 after unaligned write", sext_byte(wdat[0]), data);
        apb_read(reg_addr(1) + APB_AW'(2), data, err);
        check_flag("pslverr on unaligned read", 1'b1, err);
        check_word("unaligned read data", '0, data);
        finish_test();
    endtask

    task automatic test_bias_only();
        logic [N_FILT*PIX_W-1:0] word;
        start_test("bias_only");
        for (int i = 0; i < N_REGS; i++) begin
            reg_img[i] = '0;
        end
        reg_img[N_WGT_REGS + 0] = weight_t'(5);
        reg_img[N_WGT_REGS + 1] = weight_t'(-3);
        reg_img[N_WGT_REGS + 2] = weight_t'(0);
        load_registers();
        fill_frame(0);
        got_q.delete();
        stream_frames(1, 0);
        wait_for_results(RES_PER_FRAME);
        for (int i = 0; i < got_q.size() && i < RES_PER_FRAME; i++) begin
            word = got_q[i];
            for (int f = 0; f < N_FILT; f++) begin
                check_pixel($sformatf("result %0d filter %0d", i, f),
                            pixel_t'(reg_img[N_WGT_REGS + f]),
                            pixel_t'(word[f*PIX_W +: PIX_W]));
            end
        end
        finish_test();
    endtask

    task automatic test_random_frame();
        start_test("random_frame");
        randomize_registers();
        load_registers();
        fill_frame(0);
        got_q.delete();
        stream_frames(1, 0);
        wait_for_results(RES_PER_FRAME);
        compare_with_model(1);
        finish_test();
    endtask

    task automatic test_two_frames();
        start_test("two_frames");
        randomize_registers();
        load_registers();
        fill_frame(0);
        fill_frame(1);
        got_q.delete();
        stream_frames(2, MAX_GAP);   // back to back, random gaps
        wait_for_results(2 * RES_PER_FRAME);
        compare_with_model(2);
        finish_test();
    endtask

    initial begin
        #(WATCHDOG_NS);
        $display("watchdog: simulation ran past %0d ns without finishing", WATCHDOG_NS);
        $display("test failed");
        $finish;
    end

    initial begin
        void'($urandom(68));
        err_cnt     = 0;
        n_ok        = 0;
        n_bad       = 0;
        rst_n       = 1'b0;
        psel        = 1'b0;
        penable     = 1'b0;
        pwrite      = 1'b0;
        paddr       = '0;
        pwdata      = '0;
        pixel_valid = 1'b0;
        for (int ch = 0; ch < N_IN_CH; ch++) begin
            pixel_in[ch] = '0;
        end
        repeat (3) @(posedge clk);
        rst_n <= 1'b1;

        test_reset_state();
        test_register_access();
        test_bias_only();
        test_random_frame();
        test_two_frames();

        $display("summary: %0d tests ok, %0d with errors, %0d mismatches in all",
                 n_ok, n_bad, err_cnt);
        if (n_bad == 0 && err_cnt == 0) begin
            $display("test passed");
        end else begin
            $display("test failed");
        end
        $finish;
    end

endmodule

//--- design/conv2_layer.sv
// conv2 layer top
// three line buffers feed three filter MACs in lockstep, with the
// kernels and biases held in an APB register block

module conv2_layer
    import conv2_pkg::*;
(
    input  logic              clk,
    input  logic              rst_n,
    // APB
    input  logic              psel,
    input  logic              penable,
    input  logic              pwrite,
    input  logic [APB_AW-1:0] paddr,
    input  logic [APB_DW-1:0] pwdata,
    output logic [APB_DW-1:0] prdata,
    output logic              pready,
    output logic              pslverr,
    // pixel stream
    input  logic              pixel_valid,
    input  pixel_t            pixel_in    [N_IN_CH],
    output pixel_t            feature_out [N_FILT],
    output logic              out_valid
);

    window_t             windows [N_IN_CH];
    logic [N_IN_CH-1:0]  win_valid;
    kernel_t             kernels [N_FILT][N_IN_CH];
    weight_t             biases  [N_FILT];
    logic [N_FILT-1:0]   res_valid;

    ////////////////////////////////////////
    // input side
    ////////////////////////////////////////
    for (genvar ch = 0; ch < N_IN_CH; ch++) begin : g_buf
        conv2_line_buffer u_line_buffer (
            .clk          (clk),
            .rst_n        (rst_n),
            .pixel_valid  (pixel_valid),
            .pixel_in     (pixel_in[ch]),
            .window       (windows[ch]),
            .window_valid (win_valid[ch])
        );
    end

    conv2_weight_regs u_weight_regs (
        .clk     (clk),
        .rst_n   (rst_n),
        .psel    (psel),
        .penable (penable),
        .pwrite  (pwrite),
        .paddr   (paddr),
        .pwdata  (pwdata),
        .prdata  (prdata),
        .pready  (pready),
        .pslverr (pslverr),
        .kernels (kernels),
        .biases  (biases)
    );

    ////////////////////////////////////////
    // filters
    ////////////////////////////////////////
    for (genvar f = 0; f < N_FILT; f++) begin : g_filt
        conv2_filter_mac u_filter_mac (
            .clk          (clk),
            .rst_n        (rst_n),
            .windows      (windows),
            .kernels      (kernels[f]),
            .bias         (biases[f]),
            .window_valid (win_valid[0]),   // buffers share one stream
            .result       (feature_out[f]),
            .result_valid (res_valid[f])
        );
    end

    assign out_valid = res_valid[0];

endmodule

//--- design/conv2_weight_regs.sv
// conv2 weight registers
// APB slave holding the 225 kernel taps and 3 biases of the layer,
// with read-back and an error response on bad addresses

module conv2_weight_regs
    import conv2_pkg::*;
(
    input  logic              clk,
    input  logic              rst_n,
    input  logic              psel,
    input  logic              penable,
    input  logic              pwrite,
    input  logic [APB_AW-1:0] paddr,
    input  logic [APB_DW-1:0] pwdata,
    output logic [APB_DW-1:0] prdata,
    output logic              pready,
    output logic              pslverr,
    output kernel_t           kernels [N_FILT][N_IN_CH],
    output weight_t           biases  [N_FILT]
);

    weight_t             regs [N_REGS];
    logic [APB_AW-3:0]   reg_idx;   // word index
    logic [REG_IW-1:0]   sel;
    logic                addr_ok;
    logic                access;    // access phase of any transfer

    ////////////////////////////////////////
    // address decode
    ////////////////////////////////////////
    assign reg_idx = paddr[APB_AW-1:2];
    assign sel     = reg_idx[REG_IW-1:0];
    assign addr_ok = (paddr[1:0] == 2'b00) && (int'(reg_idx) < N_REGS);
    assign access  = psel && penable;

    assign pready  = 1'b1;   // no wait states
    assign pslverr = access && !addr_ok;

    // read data, sign-extended, zero on a bad address
    always_comb begin
        prdata = '0;
        if (psel && !pwrite && addr_ok) begin
            prdata = APB_DW'(regs[sel]);
        end
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            for (int i = 0; i < N_REGS; i++) begin
                regs[i] <= '0;
            end
        end else if (access && pwrite && addr_ok) begin
            regs[sel] <= pwdata[WGT_W-1:0];
        end
    end

    ////////////////////////////////////////
    // unpack to filters
    ////////////////////////////////////////
    always_comb begin
        for (int f = 0; f < N_FILT; f++) begin
            for (int ch = 0; ch < N_IN_CH; ch++) begin
                for (int k = 0; k < K_TAPS; k++) begin
                    kernels[f][ch][k] = regs[(f*N_IN_CH + ch)*K_TAPS + k];
                end
            end
            biases[f] = regs[N_WGT_REGS + f];   // biases follow the taps
        end
    end

    // access phase must follow a setup phase with psel held
    a_penable_in_psel : assert property (
        @(posedge clk) disable iff (!rst_n)
        penable |-> psel && $past(psel)
    );

    // error only reported in a real access phase
    a_slverr_in_access : assert property (
        @(posedge clk) disable iff (!rst_n)
        pslverr |-> psel && penable && $past(psel) && !$past(penable)
    );

endmodule

//--- design/conv2_filter_mac.sv
// conv2 filter MAC
// one output filter, sums 75 signed products over three channels,
// then scales the sum and adds the filter bias in a second stage

module conv2_filter_mac
    import conv2_pkg::*;
(
    input  logic    clk,
    input  logic    rst_n,
    input  window_t windows [N_IN_CH],
    input  kernel_t kernels [N_IN_CH],
    input  weight_t bias,
    input  logic    window_valid,
    output pixel_t  result,
    output logic    result_valid
);

    sum_t    acc;       // combinational dot product
    sum_t    sum_q;     // stage one
    sum_t    scaled;
    pixel_t  px;
    weight_t wt;
    logic    stage1_valid;

    ////////////////////////////////////////
    // stage one, 75 products
    ////////////////////////////////////////
    always_comb begin
        acc = '0;
        px  = '0;
        wt  = '0;
        for (int ch = 0; ch < N_IN_CH; ch++) begin
            for (int k = 0; k < K_TAPS; k++) begin
                px  = windows[ch][k];
                wt  = kernels[ch][k];
                acc = acc + sum_t'(px) * sum_t'(wt);   // wraps at 20 bits
            end
        end
    end

    always_ff @(posedge clk) begin
        if (window_valid) begin
            sum_q <= acc;
        end
    end

    ////////////////////////////////////////
    // stage two, scale and bias
    ////////////////////////////////////////
    assign scaled = sum_q >>> OUT_SHIFT;

    always_ff @(posedge clk) begin
        if (stage1_valid) begin
            result <= pixel_t'(scaled) + pixel_t'(bias);   // low 12 bits only
        end
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            stage1_valid <= 1'b0;
            result_valid <= 1'b0;
        end else begin
            stage1_valid <= window_valid;
            result_valid <= stage1_valid;
        end
    end

    // fixed two cycle latency from window to result
    a_latency : assert property (
        @(posedge clk) disable iff (!rst_n)
        result_valid == $past(window_valid, 2)
    );

endmodule

//--- design/conv2_line_buffer.sv
// conv2 line buffer
// keeps the last four rows of one input channel and slides a 5x5
// register window across the 12x12 frame, flagging every window
// that lies fully inside the image

module conv2_line_buffer
    import conv2_pkg::*;
(
    input  logic    clk,
    input  logic    rst_n,
    input  logic    pixel_valid,
    input  pixel_t  pixel_in,
    output window_t window,
    output logic    window_valid
);

    typedef logic [$clog2(IMG_W)-1:0]    cnt_t;
    typedef logic [$clog2(K_SIZE-1)-1:0] slot_t;

    pixel_t  row_mem [K_SIZE-1][IMG_W];   // circular store of previous rows
    pixel_t  new_col [K_SIZE];            // column entering the window
    window_t taps;                        // live shift register window
    cnt_t    col_cnt;
    cnt_t    row_cnt;
    slot_t   wr_slot;
    logic    hit;                         // accepted pixel closed a window

    // row r lives in slot r mod 4, and 12 rows per frame keeps that
    // mapping intact across frame boundaries
    assign wr_slot = slot_t'(row_cnt);

    ////////////////////////////////////////
    // column assembly
    ////////////////////////////////////////
    always_comb begin
        for (int r = 0; r < K_SIZE - 1; r++) begin
            // slot wr_slot still holds row - 4, the oldest row
            new_col[r] = row_mem[wr_slot + slot_t'(r)][col_cnt];
        end
        new_col[K_SIZE-1] = pixel_in;   // bottom row is the live pixel
    end

    // row memory and window shift, payload only
    always_ff @(posedge clk) begin
        if (pixel_valid) begin
            row_mem[wr_slot][col_cnt] <= pixel_in;   // overwrites row - 4
            for (int r = 0; r < K_SIZE; r++) begin
                for (int c = 0; c < K_SIZE - 1; c++) begin
                    taps[r*K_SIZE + c] <= taps[r*K_SIZE + c + 1];
                end
                taps[r*K_SIZE + K_SIZE - 1] <= new_col[r];   // newest on the right
            end
        end
    end

    ////////////////////////////////////////
    // position tracking
    ////////////////////////////////////////
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            col_cnt      <= '0;
            row_cnt      <= '0;
            hit          <= 1'b0;
            window_valid <= 1'b0;
        end else begin
            hit <= pixel_valid
                && (row_cnt >= cnt_t'(K_SIZE - 1))
                && (col_cnt >= cnt_t'(K_SIZE - 1));
            window_valid <= hit;
            if (pixel_valid) begin
                if (col_cnt == cnt_t'(IMG_W - 1)) begin
                    col_cnt <= '0;
                    if (row_cnt == cnt_t'(IMG_H - 1)) begin
                        row_cnt <= '0;   // frame done
                    end else begin
                        row_cnt <= row_cnt + cnt_t'(1);
                    end
                end else begin
                    col_cnt <= col_cnt + cnt_t'(1);
                end
            end
        end
    end

    // snapshot held steady while the filters read it
    always_ff @(posedge clk) begin
        if (hit) begin
            window <= taps;
        end
    end

    // a window can only appear behind an accepted pixel
    a_window_after_pixel : assert property (
        @(posedge clk) disable iff (!rst_n)
        window_valid |-> $past(pixel_valid, 2)
    );

endmodule

//--- design/conv2_pkg.sv
// conv2 package
// dimensions, widths and data types shared by the second convolution
// layer of the MNIST network

package conv2_pkg;

    ////////////////////////////////////////
    // layer geometry
    ////////////////////////////////////////
    localparam int IMG_W   = 12;
    localparam int IMG_H   = 12;
    localparam int K_SIZE  = 5;
    localparam int K_TAPS  = K_SIZE * K_SIZE;
    localparam int N_IN_CH = 3;
    localparam int N_FILT  = 3;
    localparam int OUT_W   = IMG_W - K_SIZE + 1;   // 8
    localparam int OUT_H   = IMG_H - K_SIZE + 1;   // 8

    ////////////////////////////////////////
    // arithmetic
    ////////////////////////////////////////
    localparam int PIX_W     = 12;
    localparam int WGT_W     = 8;
    localparam int SUM_W     = 20;
    localparam int OUT_SHIFT = 7;   // sum scaling before bias

    ////////////////////////////////////////
    // register map
    ////////////////////////////////////////
    localparam int N_WGT_REGS = N_FILT * N_IN_CH * K_TAPS;   // 225 taps
    localparam int N_REGS     = N_WGT_REGS + N_FILT;         // plus biases
    localparam int REG_IW     = $clog2(N_REGS);              // register index bits
    localparam int APB_AW     = 12;
    localparam int APB_DW     = 32;

    typedef logic signed [PIX_W-1:0] pixel_t;
    typedef logic signed [WGT_W-1:0] weight_t;
    typedef logic signed [SUM_W-1:0] sum_t;

    // index k = row * K_SIZE + col, row 0 is the oldest
    typedef pixel_t  [K_TAPS-1:0] window_t;
    typedef weight_t [K_TAPS-1:0] kernel_t;

endpackage
